// ==== Makefile ====
# Verilator build and run of the analog data path testbench

TOP := analog_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run exits with a non-zero status when the testbench fails
test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000

clean:
	rm -rf obj_dir

// ==== build.f ====
hw/sig_pkg.sv
hw/bus_pkg.sv
hw/adc_capture.sv
hw/linear_cal.sv
hw/cal_regs.sv
hw/dac_output.sv
hw/analog_top.sv
test/analog_props.sv
test/analog_tb.sv

// ==== hw/adc_capture.sv ====
`timescale 1ns/1ps

module adc_capture import sig_pkg::*; (
  input  logic                             adc_clk,
  input  logic                             top_rst,
  // Raw converter words
  input  logic        [DAT_W-1:0]          adc_dat_a_i,
  input  logic        [DAT_W-1:0]          adc_dat_b_i,
  // Digital loopback
  input  logic                             loop_en_i,
  input  logic signed [CHN-1:0][DAT_W-1:0] loop_dat_i,
  // Two's complement samples
  output logic signed [CHN-1:0][DAT_W-1:0] cap_dat_o
);

//////////////////////////////////////////////////////////////////////
// Input registers
//////////////////////////////////////////////////////////////////////

// Converted samples, one per channel
logic [CHN-1:0][DAT_W-1:0] raw_q;

// Capture and convert in one step
// Channel A goes to index 0, channel B to index 1
always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
  begin
    raw_q <= '0;
  end
  else
  begin
    raw_q[0] <= slope_flip(adc_dat_a_i);
    raw_q[1] <= slope_flip(adc_dat_b_i);
  end
end

//////////////////////////////////////////////////////////////////////
// Loopback select
//////////////////////////////////////////////////////////////////////

// Loopback replaces each channel by the DAC sample of the same index
// No register here so the loop adds only the DAC path latency
always_comb
begin
  for (int unsigned ch = 0; ch < CHN; ch++)
  begin
    if (loop_en_i)
      cap_dat_o[ch] = loop_dat_i[ch];
    else
      cap_dat_o[ch] = raw_q[ch];
  end
end

endmodule

// ==== hw/analog_top.sv ====
`timescale 1ns/1ps

module analog_top import sig_pkg::*, bus_pkg::*; #(
  // Channels per side
  parameter int unsigned CHN_N = CHN
)(
  input  logic                               adc_clk,
  input  logic                               top_rst,
  // ADC
  input  logic        [DAT_W-1:0]            adc_dat_a_i,
  input  logic        [DAT_W-1:0]            adc_dat_b_i,
  output logic signed [CHN_N-1:0][DAT_W-1:0] adc_dat_o,
  // Generator samples
  input  logic signed [CHN_N-1:0][DAT_W-1:0] gen_dat_i,
  // DAC
  output logic        [DAT_W-1:0]            dac_dat_o,
  output logic                               dac_sel_o,
  output logic                               dac_rst_o,
  // System bus
  input  logic        [ADDR_W-1:0]           sys_addr_i,
  input  logic        [DATA_W-1:0]           sys_wdata_i,
  input  logic                               sys_wen_i,
  input  logic                               sys_ren_i,
  output logic        [DATA_W-1:0]           sys_rdata_o,
  output logic                               sys_ack_o,
  output logic                               sys_err_o
);

// Loopback enable
logic                               loop_en;
// Captured or looped samples
logic signed [CHN_N-1:0][DAT_W-1:0] cap_dat;
// Calibrated DAC samples
logic signed [CHN_N-1:0][DAT_W-1:0] dac_cal;
// Calibration settings
logic        [CHN_N-1:0][MUL_W-1:0] adc_mul;
logic        [CHN_N-1:0][SUM_W-1:0] adc_sum;
logic        [CHN_N-1:0][MUL_W-1:0] dac_mul;
logic        [CHN_N-1:0][SUM_W-1:0] dac_sum;

//////////////////////////////////////////////////////////////////////
// ADC capture
//////////////////////////////////////////////////////////////////////

adc_capture u_adc_capture (
  .adc_clk     (adc_clk),
  .top_rst     (top_rst),
  .adc_dat_a_i (adc_dat_a_i),
  .adc_dat_b_i (adc_dat_b_i),
  .loop_en_i   (loop_en),
  .loop_dat_i  (dac_cal),
  .cap_dat_o   (cap_dat)
);

//////////////////////////////////////////////////////////////////////
// Calibration, one stage per channel and side
//////////////////////////////////////////////////////////////////////

for (genvar ch = 0; ch < CHN_N; ch++)
begin : g_chn
  // ADC side
  linear_cal #(
    .DWI (DAT_W),
    .DWO (DAT_W),
    .DWM (MUL_W)
  ) u_adc_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (cap_dat[ch]),
    .mul_i   (adc_mul[ch]),
    .sum_i   (adc_sum[ch]),
    .dat_o   (adc_dat_o[ch])
  );

  // DAC side
  linear_cal #(
    .DWI (DAT_W),
    .DWO (DAT_W),
    .DWM (MUL_W)
  ) u_dac_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (gen_dat_i[ch]),
    .mul_i   (dac_mul[ch]),
    .sum_i   (dac_sum[ch]),
    .dat_o   (dac_cal[ch])
  );
end

//////////////////////////////////////////////////////////////////////
// DAC output and register block
//////////////////////////////////////////////////////////////////////

dac_output u_dac_output (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .cal_dat_i (dac_cal),
  .dac_dat_o (dac_dat_o),
  .dac_sel_o (dac_sel_o),
  .dac_rst_o (dac_rst_o)
);

cal_regs #(
  .CHN_N (CHN_N)
) u_cal_regs (
  .adc_clk     (adc_clk),
  .top_rst     (top_rst),
  .sys_addr_i  (sys_addr_i),
  .sys_wdata_i (sys_wdata_i),
  .sys_wen_i   (sys_wen_i),
  .sys_ren_i   (sys_ren_i),
  .sys_rdata_o (sys_rdata_o),
  .sys_ack_o   (sys_ack_o),
  .sys_err_o   (sys_err_o),
  .adc_mul_o   (adc_mul),
  .adc_sum_o   (adc_sum),
  .dac_mul_o   (dac_mul),
  .dac_sum_o   (dac_sum),
  .loop_en_o   (loop_en)
);

endmodule

// ==== hw/bus_pkg.sv ====
package bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // System bus
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Eight regions selected by address bits 22:20
  localparam int unsigned RGN_LSB = 20;
  localparam int unsigned RGN_W   = 3;
  localparam logic [RGN_W-1:0] REG_REGION = 3'd1;

  // Byte offset inside a region
  localparam int unsigned OFS_W = 20;

  // Calibration map for channel 0
  localparam logic [OFS_W-1:0] OFS_ADC_MUL = 20'h00;
  localparam logic [OFS_W-1:0] OFS_ADC_SUM = 20'h04;
  localparam logic [OFS_W-1:0] OFS_DAC_MUL = 20'h10;
  localparam logic [OFS_W-1:0] OFS_DAC_SUM = 20'h14;
  // Next channel sits one stride higher
  localparam logic [OFS_W-1:0] CH_STEP     = 20'h08;
  // Digital loopback enable in bit 0
  localparam logic [OFS_W-1:0] OFS_LOOP    = 20'h20;

  // Gain view of a data word
  typedef struct packed {
    logic        [DATA_W-sig_pkg::MUL_W-1:0] pad;
    logic signed [sig_pkg::MUL_W-1:0]        mul;
  } cal_mul_t;

  // Offset view of a data word
  typedef struct packed {
    logic        [DATA_W-sig_pkg::SUM_W-1:0] pad;
    logic signed [sig_pkg::SUM_W-1:0]        sum;
  } cal_sum_t;

  // One written word, read as gain or as offset
  typedef union packed {
    logic [DATA_W-1:0] raw;
    cal_mul_t          gain;
    cal_sum_t          ofs;
  } cal_word_u;

endpackage

// ==== hw/cal_regs.sv ====
`timescale 1ns/1ps

module cal_regs import sig_pkg::*, bus_pkg::*; #(
  parameter int unsigned CHN_N = CHN
)(
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // System bus
  input  logic [ADDR_W-1:0]             sys_addr_i,
  input  logic [DATA_W-1:0]             sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [DATA_W-1:0]             sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o,
  // Calibration settings
  output logic [CHN_N-1:0][MUL_W-1:0]   adc_mul_o,
  output logic [CHN_N-1:0][SUM_W-1:0]   adc_sum_o,
  output logic [CHN_N-1:0][MUL_W-1:0]   dac_mul_o,
  output logic [CHN_N-1:0][SUM_W-1:0]   dac_sum_o,
  output logic                          loop_en_o
);

cal_word_u         wr_word;
logic [OFS_W-1:0]  reg_ofs;
logic              in_rgn;
logic              map_hit;
logic              wr_en;
logic [CHN_N-1:0]  adc_mul_hit;
logic [CHN_N-1:0]  adc_sum_hit;
logic [CHN_N-1:0]  dac_mul_hit;
logic [CHN_N-1:0]  dac_sum_hit;
logic              loop_hit;
logic [DATA_W-1:0] rd_word;

// Register offset of a field for one channel
function automatic logic [OFS_W-1:0] ch_ofs(input logic [OFS_W-1:0] base,
                                            input int unsigned ch);
  return base + OFS_W'(ch) * CH_STEP;
endfunction

// Read back with sign extension
function automatic logic [DATA_W-1:0] sext_mul(input logic [MUL_W-1:0] v);
  return {{(DATA_W-MUL_W){v[MUL_W-1]}}, v};
endfunction

function automatic logic [DATA_W-1:0] sext_sum(input logic [SUM_W-1:0] v);
  return {{(DATA_W-SUM_W){v[SUM_W-1]}}, v};
endfunction

//////////////////////////////////////////////////////////////////////
// Address decode
//////////////////////////////////////////////////////////////////////

assign wr_word.raw = sys_wdata_i;
assign reg_ofs     = sys_addr_i[OFS_W-1:0];
assign in_rgn      = sys_addr_i[RGN_LSB+RGN_W-1:RGN_LSB] == REG_REGION;
assign wr_en       = sys_wen_i & in_rgn;

always_comb
begin
  map_hit     = 1'b0;
  rd_word     = '0;
  adc_mul_hit = '0;
  adc_sum_hit = '0;
  dac_mul_hit = '0;
  dac_sum_hit = '0;
  // Per channel fields
  for (int unsigned ch = 0; ch < CHN_N; ch++)
  begin
    adc_mul_hit[ch] = reg_ofs == ch_ofs(OFS_ADC_MUL, ch);
    adc_sum_hit[ch] = reg_ofs == ch_ofs(OFS_ADC_SUM, ch);
    dac_mul_hit[ch] = reg_ofs == ch_ofs(OFS_DAC_MUL, ch);
    dac_sum_hit[ch] = reg_ofs == ch_ofs(OFS_DAC_SUM, ch);
    if (adc_mul_hit[ch])
      rd_word = sext_mul(adc_mul_o[ch]);
    if (adc_sum_hit[ch])
      rd_word = sext_sum(adc_sum_o[ch]);
    if (dac_mul_hit[ch])
      rd_word = sext_mul(dac_mul_o[ch]);
    if (dac_sum_hit[ch])
      rd_word = sext_sum(dac_sum_o[ch]);
  end
  // Loopback flag reads back as a plain bit
  loop_hit = reg_ofs == OFS_LOOP;
  if (loop_hit)
    rd_word = DATA_W'(loop_en_o);
  map_hit = |{adc_mul_hit, adc_sum_hit, dac_mul_hit, dac_sum_hit, loop_hit};
end

//////////////////////////////////////////////////////////////////////
// Settings
//////////////////////////////////////////////////////////////////////

// Gains reset to unity, offsets to zero, loopback off
always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
  begin
    adc_mul_o <= {CHN_N{MUL_ONE}};
    adc_sum_o <= '0;
    dac_mul_o <= {CHN_N{MUL_ONE}};
    dac_sum_o <= '0;
    loop_en_o <= 1'b0;
  end
  else if (wr_en)
  begin
    // Field view picked by the decoded offset
    for (int unsigned ch = 0; ch < CHN_N; ch++)
    begin
      if (adc_mul_hit[ch])
        adc_mul_o[ch] <= wr_word.gain.mul;
      if (adc_sum_hit[ch])
        adc_sum_o[ch] <= wr_word.ofs.sum;
      if (dac_mul_hit[ch])
        dac_mul_o[ch] <= wr_word.gain.mul;
      if (dac_sum_hit[ch])
        dac_sum_o[ch] <= wr_word.ofs.sum;
    end
    if (loop_hit)
      loop_en_o <= wr_word.raw[0];
  end
end

//////////////////////////////////////////////////////////////////////
// Bus response
//////////////////////////////////////////////////////////////////////

// Every strobe gets an ack one cycle later, in any region
// Error flags foreign regions and holes in the map
always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
  begin
    sys_ack_o <= 1'b0;
    sys_err_o <= 1'b0;
  end
  else
  begin
    sys_ack_o <= sys_wen_i | sys_ren_i;
    sys_err_o <= (sys_wen_i | sys_ren_i) & ~(in_rgn & map_hit);
  end
end

// Read data valid together with the ack
always_ff @(posedge adc_clk)
begin
  if (sys_ren_i)
    sys_rdata_o <= in_rgn ? rd_word : '0;
end

endmodule

// ==== hw/dac_output.sv ====
`timescale 1ns/1ps

module dac_output import sig_pkg::*; (
  input  logic                             adc_clk,
  input  logic                             top_rst,
  // Calibrated samples
  input  logic signed [CHN-1:0][DAT_W-1:0] cal_dat_i,
  // Interleaved DAC bus
  output logic        [DAT_W-1:0]          dac_dat_o,
  output logic                             dac_sel_o,
  output logic                             dac_rst_o
);

// Both channels in converter format
logic [CHN-1:0][DAT_W-1:0] dac_q;
// DAC reset shift register
logic [1:0]                rst_sr;

//////////////////////////////////////////////////////////////////////
// Output format
//////////////////////////////////////////////////////////////////////

// Back to unsigned with negative slope
always_ff @(posedge adc_clk)
begin
  for (int unsigned ch = 0; ch < CHN; ch++)
  begin
    dac_q[ch] <= slope_flip(cal_dat_i[ch]);
  end
end

//////////////////////////////////////////////////////////////////////
// Interleave
//////////////////////////////////////////////////////////////////////

// Select flips every clock, low out of reset
always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
    dac_sel_o <= 1'b0;
  else
    dac_sel_o <= ~dac_sel_o;
end

// High select carries channel 0
assign dac_dat_o = dac_sel_o ? dac_q[0] : dac_q[1];

// Hold the DAC in reset one full cycle past top_rst release
always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
    rst_sr <= 2'b11;
  else
    rst_sr <= {rst_sr[0], 1'b0};
end

assign dac_rst_o = rst_sr[1];

endmodule

// ==== hw/linear_cal.sv ====
`timescale 1ns/1ps

module linear_cal #(
  // Input sample width
  parameter int unsigned DWI = 14,
  // Output sample width, also the offset width
  parameter int unsigned DWO = 14,
  // Gain width, fixed point with DWM-2 fraction bits
  parameter int unsigned DWM = 16
)(
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // Sample in
  input  logic signed [DWI-1:0] dat_i,
  // Gain and offset
  input  logic signed [DWM-1:0] mul_i,
  input  logic signed [DWO-1:0] sum_i,
  // Calibrated sample out
  output logic signed [DWO-1:0] dat_o
);

// Full product width
localparam int unsigned DWP = DWI + DWM;
// Product after dropping the fraction bits
// Gain range is about +-2 so two integer bits are enough
localparam int unsigned DWS = DWI + 2;
// One more bit to hold the offset sum
localparam int unsigned DWA = DWS + 1;

logic signed [DWP-1:0] prod;
logic signed [DWS-1:0] prod_q;
logic signed [DWA-1:0] acc;
logic                  acc_ovf;
logic signed [DWO-1:0] acc_sat;

//////////////////////////////////////////////////////////////////////
// Stage 1 gain
//////////////////////////////////////////////////////////////////////

assign prod = dat_i * mul_i;

// Dropping low bits of a signed value rounds toward minus infinity
always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
    prod_q <= '0;
  else
    prod_q <= prod[DWP-1:DWM-2];
end

//////////////////////////////////////////////////////////////////////
// Stage 2 offset and saturation
//////////////////////////////////////////////////////////////////////

assign acc = prod_q + sum_i;

// Overflow when the bits above the output sign differ from it
assign acc_ovf = ~(&acc[DWA-1:DWO-1]) & (|acc[DWA-1:DWO-1]);

// Clamp to the most positive or most negative code
always_comb
begin
  if (acc_ovf)
    acc_sat = {acc[DWA-1], {(DWO-1){~acc[DWA-1]}}};
  else
    acc_sat = acc[DWO-1:0];
end

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
    dat_o <= '0;
  else
    dat_o <= acc_sat;
end

endmodule

// ==== hw/sig_pkg.sv ====
package sig_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sample path widths
  //////////////////////////////////////////////////////////////////////

  // ADC and DAC sample width
  localparam int unsigned DAT_W = 14;

  // Gain width
  localparam int unsigned MUL_W = 16;

  // Offset width
  localparam int unsigned SUM_W = 14;

  // Number of analog channels per side
  localparam int unsigned CHN = 2;

  // Unity gain is 2^14 so the gain is a 1.14 fixed point value
  localparam logic [MUL_W-1:0] MUL_ONE = 16'h4000;

  // Converter words are offset binary with negative slope
  // Keeping the MSB and inverting the rest maps them to two's complement
  // The same mapping applied again gives the converter word back
  function automatic logic [DAT_W-1:0] slope_flip(input logic [DAT_W-1:0] w);
    return {w[DAT_W-1], ~w[DAT_W-2:0]};
  endfunction

endpackage

// ==== test/analog_props.sv ====
`timescale 1ns/1ps

module analog_props import sig_pkg::*, bus_pkg::*; (
  input logic                             adc_clk,
  input logic                             top_rst,
  input logic        [DAT_W-1:0]          adc_dat_a_i,
  input logic        [DAT_W-1:0]          adc_dat_b_i,
  input logic signed [CHN-1:0][DAT_W-1:0] adc_dat_o,
  input logic signed [CHN-1:0][DAT_W-1:0] gen_dat_i,
  input logic        [DAT_W-1:0]          dac_dat_o,
  input logic                             dac_sel_o,
  input logic                             dac_rst_o,
  input logic        [ADDR_W-1:0]         sys_addr_i,
  input logic        [DATA_W-1:0]         sys_wdata_i,
  input logic                             sys_wen_i,
  input logic                             sys_ren_i,
  input logic        [DATA_W-1:0]         sys_rdata_o,
  input logic                             sys_ack_o,
  input logic                             sys_err_o
);

// Failed assertions so far
int                              fail_cnt = 0;
// Shadow of the register map in read-back form
// One word per 4-byte slot
logic [DATA_W-1:0]               shadow [9];
logic [OFS_W-1:0]                ofs;
logic [3:0]                      slot;
logic                            map_ok;
// Saturating count of cycles since the last write strobe
logic [2:0]                      quiet;
// Saturating count of cycles since reset release
logic [1:0]                      rst_age;
logic [DATA_W-1:0]               rd_exp;
logic                            err_exp;
logic [CHN-1:0][DAT_W-1:0]       raw_in;
logic [CHN-1:0][DAT_W-1:0]       adc_new;
logic [CHN-1:0][DAT_W-1:0]       lpb_new;
logic [CHN-1:0][DAT_W-1:0]       dac_new;
// Expected outputs, one entry per cycle of latency
logic [2:0][CHN-1:0][DAT_W-1:0]  adc_pipe;
logic [3:0][CHN-1:0][DAT_W-1:0]  lpb_pipe;
logic [2:0][CHN-1:0][DAT_W-1:0]  dac_pipe;

// Offset binary with negative slope
// 0x1FFF is zero and 0x0000 is full positive
function automatic int to_value(input logic [DAT_W-1:0] w);
  return 8191 - int'(w);
endfunction

function automatic logic [DAT_W-1:0] to_word(input int v);
  return DAT_W'(8191 - v);
endfunction

// Gain is 1.14 fixed point and the shift rounds toward minus infinity
function automatic int cal_rule(input int x, input int g, input int s);
  int y;
  y = ((x * g) >>> 14) + s;
  if (y > 8191)
    y = 8191;
  else if (y < -8192)
    y = -8192;
  return y;
endfunction

// Odd slots are 14-bit offsets, even ones 16-bit gains, slot 8 the loop bit
function automatic logic [DATA_W-1:0] field_val(input logic [3:0] s,
                                                input logic [DATA_W-1:0] d);
  if (s == 4'd8)
    return {31'b0, d[0]};
  else if (s[0])
    return {{18{d[13]}}, d[13:0]};
  else
    return {{16{d[15]}}, d[15:0]};
endfunction

//////////////////////////////////////////////////////////////////////
// Register shadow
//////////////////////////////////////////////////////////////////////

assign ofs    = sys_addr_i[OFS_W-1:0];
assign slot   = ofs[5:2];
assign map_ok = sys_addr_i[22:20] == REG_REGION && ofs[1:0] == 2'b00 && ofs <= OFS_LOOP;

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
  begin
    for (int i = 0; i < 9; i++)
      shadow[i] <= (i < 8 && i % 2 == 0) ? 32'h4000 : 32'h0;
    quiet <= '0;
  end
  else
  begin
    if (sys_wen_i && map_ok)
      shadow[slot] <= field_val(slot, sys_wdata_i);
    if (sys_wen_i)
      quiet <= '0;
    else if (quiet != 3'd7)
      quiet <= quiet + 3'd1;
  end
end

always_ff @(posedge adc_clk)
begin
  err_exp <= !map_ok;
  if (sys_ren_i && map_ok)
    rd_exp <= shadow[slot];
end

//////////////////////////////////////////////////////////////////////
// Expected samples
//////////////////////////////////////////////////////////////////////

assign raw_in = {adc_dat_b_i, adc_dat_a_i};

always_comb
begin
  int dac_y;
  for (int ch = 0; ch < CHN; ch++)
  begin
    // DAC side first since it also feeds the loopback
    dac_y = cal_rule($signed(gen_dat_i[ch]), $signed(shadow[4+2*ch]),
                     $signed(shadow[5+2*ch]));
    dac_new[ch] = to_word(dac_y);
    lpb_new[ch] = DAT_W'(cal_rule(dac_y, $signed(shadow[2*ch]),
                                  $signed(shadow[2*ch+1])));
    adc_new[ch] = DAT_W'(cal_rule(to_value(raw_in[ch]), $signed(shadow[2*ch]),
                                  $signed(shadow[2*ch+1])));
  end
end

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
  begin
    adc_pipe <= '0;
    lpb_pipe <= '0;
    dac_pipe <= '0;
  end
  else
  begin
    adc_pipe <= {adc_pipe[1:0], adc_new};
    lpb_pipe <= {lpb_pipe[2:0], lpb_new};
    dac_pipe <= {dac_pipe[1:0], dac_new};
  end
end

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
    rst_age <= '0;
  else if (rst_age != 2'd3)
    rst_age <= rst_age + 2'd1;
end

//////////////////////////////////////////////////////////////////////
// Bus response
//////////////////////////////////////////////////////////////////////

a_ack: assert property (@(posedge adc_clk) disable iff (top_rst)
  (sys_wen_i || sys_ren_i) |=> sys_ack_o)
else
begin
  $error("FAILED %0t sys_ack_o got %0b exp 1", $time, $sampled(sys_ack_o));
  fail_cnt = fail_cnt + 1;
end

// No ack without a strobe
a_no_ack: assert property (@(posedge adc_clk) disable iff (top_rst)
  !(sys_wen_i || sys_ren_i) |=> !sys_ack_o)
else
begin
  $error("FAILED %0t sys_ack_o got %0b exp 0", $time, $sampled(sys_ack_o));
  fail_cnt = fail_cnt + 1;
end

a_err: assert property (@(posedge adc_clk) disable iff (top_rst)
  (sys_wen_i || sys_ren_i) |=> sys_err_o == err_exp)
else
begin
  $error("FAILED %0t sys_err_o got %0b exp %0b", $time,
         $sampled(sys_err_o), $sampled(err_exp));
  fail_cnt = fail_cnt + 1;
end

a_rdata: assert property (@(posedge adc_clk) disable iff (top_rst)
  (sys_ren_i && map_ok) |=> sys_rdata_o == rd_exp)
else
begin
  $error("FAILED %0t sys_rdata_o got %08h exp %08h", $time,
         $sampled(sys_rdata_o), $sampled(rd_exp));
  fail_cnt = fail_cnt + 1;
end

//////////////////////////////////////////////////////////////////////
// Sample paths
//////////////////////////////////////////////////////////////////////

// DAC reset stays high through the first cycle after release
a_dac_rst: assert property (@(posedge adc_clk) disable iff (top_rst)
  dac_rst_o == (rst_age < 2'd2))
else
begin
  $error("FAILED %0t dac_rst_o got %0b exp %0b", $time, $sampled(dac_rst_o),
         $sampled(rst_age) < 2'd2);
  fail_cnt = fail_cnt + 1;
end

// Select comes out of reset low
a_sel_rst: assert property (@(posedge adc_clk) disable iff (top_rst)
  rst_age == 2'd0 |-> !dac_sel_o)
else
begin
  $error("FAILED %0t dac_sel_o got %0b exp 0", $time, $sampled(dac_sel_o));
  fail_cnt = fail_cnt + 1;
end

a_sel: assert property (@(posedge adc_clk) disable iff (top_rst)
  1'b1 |=> dac_sel_o != $past(dac_sel_o))
else
begin
  $error("dac_sel_o did not toggle at %0t", $time);
  fail_cnt = fail_cnt + 1;
end

// High select carries channel 0
a_dac: assert property (@(posedge adc_clk) disable iff (top_rst)
  quiet >= 3'd5 |-> dac_dat_o == (dac_sel_o ? dac_pipe[2][0] : dac_pipe[2][1]))
else
begin
  $error("FAILED %0t dac_dat_o got %04h exp %04h", $time, $sampled(dac_dat_o),
         $sampled(dac_sel_o) ? $sampled(dac_pipe[2][0]) : $sampled(dac_pipe[2][1]));
  fail_cnt = fail_cnt + 1;
end

for (genvar ch = 0; ch < CHN; ch++)
begin : g_chk
  a_adc: assert property (@(posedge adc_clk) disable iff (top_rst)
    (quiet >= 3'd5 && !shadow[8][0]) |-> adc_dat_o[ch] == adc_pipe[2][ch])
  else
  begin
    $error("FAILED %0t adc_dat_o[%0d] got %0d exp %0d", $time, ch,
           $signed($sampled(adc_dat_o[ch])), $signed($sampled(adc_pipe[2][ch])));
    fail_cnt = fail_cnt + 1;
  end

  // Loopback adds the two DAC cycles minus the capture register
  a_loop: assert property (@(posedge adc_clk) disable iff (top_rst)
    (quiet >= 3'd5 && shadow[8][0]) |-> adc_dat_o[ch] == lpb_pipe[3][ch])
  else
  begin
    $error("FAILED %0t adc_dat_o[%0d] got %0d exp %0d", $time, ch,
           $signed($sampled(adc_dat_o[ch])), $signed($sampled(lpb_pipe[3][ch])));
    fail_cnt = fail_cnt + 1;
  end
end

endmodule

// ==== test/analog_tb.sv ====
`timescale 1ns/1ps

module analog_tb import sig_pkg::*, bus_pkg::*; ();

// Calibration region base address
localparam logic [ADDR_W-1:0] CAL_BASE = 32'h0010_0000;

logic                             adc_clk;
logic                             top_rst;
logic        [DAT_W-1:0]          adc_dat_a;
logic        [DAT_W-1:0]          adc_dat_b;
logic signed [CHN-1:0][DAT_W-1:0] adc_dat;
logic signed [CHN-1:0][DAT_W-1:0] gen_dat;
logic        [DAT_W-1:0]          dac_dat;
logic                             dac_sel;
logic                             dac_rst;
logic        [ADDR_W-1:0]         sys_addr;
logic        [DATA_W-1:0]         sys_wdata;
logic                             sys_wen;
logic                             sys_ren;
logic        [DATA_W-1:0]         sys_rdata;
logic                             sys_ack;
logic                             sys_err;
// Fibonacci LFSR state
logic        [31:0]               lfsr = 32'h4bae_9469;

analog_top #(
  .CHN_N (CHN)
) u_dut (
  .adc_clk     (adc_clk),
  .top_rst     (top_rst),
  .adc_dat_a_i (adc_dat_a),
  .adc_dat_b_i (adc_dat_b),
  .adc_dat_o   (adc_dat),
  .gen_dat_i   (gen_dat),
  .dac_dat_o   (dac_dat),
  .dac_sel_o   (dac_sel),
  .dac_rst_o   (dac_rst),
  .sys_addr_i  (sys_addr),
  .sys_wdata_i (sys_wdata),
  .sys_wen_i   (sys_wen),
  .sys_ren_i   (sys_ren),
  .sys_rdata_o (sys_rdata),
  .sys_ack_o   (sys_ack),
  .sys_err_o   (sys_err)
);

// Port checkers inside every analog_top
bind analog_top analog_props u_props (.*);

// 40 ns period
initial adc_clk = 1'b0;
always #20 adc_clk = ~adc_clk;

// Taps 32 22 2 1, one step per bit
function automatic logic [31:0] take_bits(input int unsigned n);
  logic [31:0] v;
  v = '0;
  for (int unsigned i = 0; i < n; i++)
  begin
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    v = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

task automatic abort_run(input string why);
  $display("Test failed");
  $fatal(1, "%s", why);
endtask

// One strobe cycle, then wait for the ack
task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
  int waited;
  @(negedge adc_clk);
  sys_addr  = addr;
  sys_wdata = data;
  sys_wen   = wr;
  sys_ren   = ~wr;
  @(negedge adc_clk);
  sys_wen = 1'b0;
  sys_ren = 1'b0;
  waited  = 0;
  while (!sys_ack)
  begin
    if (waited == 8)
      abort_run("no ack on the system bus");
    else
    begin
      @(negedge adc_clk);
      waited++;
    end
  end
endtask

// Write one calibration slot and read it back
task automatic set_slot(input int unsigned slot, input logic [DATA_W-1:0] data);
  bus_access(1'b1, CAL_BASE | (32'(slot) << 2), data);
  bus_access(1'b0, CAL_BASE | (32'(slot) << 2), '0);
endtask

// New ADC words every cycle, generator held for hold cycles
task automatic drive_samples(input int cycles, input int hold);
  for (int i = 0; i < cycles; i++)
  begin
    @(negedge adc_clk);
    adc_dat_a = DAT_W'(take_bits(DAT_W));
    adc_dat_b = DAT_W'(take_bits(DAT_W));
    if (i % hold == 0)
    begin
      gen_dat[0] = DAT_W'(take_bits(DAT_W));
      gen_dat[1] = DAT_W'(take_bits(DAT_W));
    end
  end
endtask

// Stop at the first failed assertion
always @(negedge adc_clk)
begin
  if (u_dut.u_props.fail_cnt != 0)
    abort_run("an assertion on the DUT ports failed");
end

initial
begin
  top_rst   = 1'b1;
  adc_dat_a = '0;
  adc_dat_b = '0;
  gen_dat   = '0;
  sys_addr  = '0;
  sys_wdata = '0;
  sys_wen   = 1'b0;
  sys_ren   = 1'b0;
  repeat (4) @(posedge adc_clk);
  @(negedge adc_clk);
  top_rst = 1'b0;

  ////////////////////////////////////////////////////////////////////
  // Bus map
  ////////////////////////////////////////////////////////////////////

  // Reset defaults
  for (int unsigned s = 0; s < 9; s++)
    bus_access(1'b0, CAL_BASE | (32'(s) << 2), '0);
  // Foreign regions and holes in the map
  bus_access(1'b1, 32'h0000_0000, 32'h0000_1234);
  bus_access(1'b0, 32'h0020_0004, '0);
  bus_access(1'b1, 32'h0070_0010, 32'h0000_0001);
  bus_access(1'b0, CAL_BASE | 32'h24, '0);
  bus_access(1'b1, CAL_BASE | 32'h02, 32'h0000_7fff);
  bus_access(1'b0, CAL_BASE | 32'h1000, '0);

  ////////////////////////////////////////////////////////////////////
  // Calibrated paths
  ////////////////////////////////////////////////////////////////////

  // Unity gain, zero offset
  drive_samples(40, 1);
  // Random gains and offsets on both sides
  for (int unsigned s = 0; s < 8; s++)
    set_slot(s, take_bits(32));
  drive_samples(60, 1);
  drive_samples(60, 5);
  // Gain near +-2 with large offsets drives both rails
  set_slot(0, 32'h0000_7fff);
  set_slot(1, 32'h0000_0fa0);
  set_slot(2, 32'h0000_8001);
  set_slot(3, 32'hffff_f060);
  drive_samples(60, 1);

  // Loopback at unity on both sides
  for (int unsigned s = 0; s < 8; s++)
    set_slot(s, (s % 2 == 0) ? 32'h0000_4000 : 32'h0);
  set_slot(8, 32'h0000_0001);
  drive_samples(60, 6);
  set_slot(8, 32'h0000_0000);
  drive_samples(20, 1);

  repeat (8) @(negedge adc_clk);
  if (u_dut.u_props.fail_cnt == 0)
  begin
    $display("Test completed successfully");
    $finish;
  end
  else
  begin
    abort_run("assertion failures were counted");
  end
end

endmodule
